// File: verilog/sdram_pkg.sv
// SDRAM address and data types, pin commands, mode register, timing and controller states.
package sdram_pkg;

  localparam int bank_width = 2;
  localparam int row_width  = 12;
  localparam int col_width  = 8;

  typedef logic [bank_width-1:0]                     sdram_bank_t;
  typedef logic [row_width-1:0]                      sdram_row_t;
  typedef logic [col_width-1:0]                      sdram_col_t;
  typedef logic [bank_width+row_width+col_width-1:0] sdram_addr_t; // {bank, row, col}.
  typedef logic [15:0]                               sdram_word_t;

  typedef logic [14:0] wait_cnt_t;
  typedef logic [8:0]  burst_cnt_t;
  typedef logic [10:0] refresh_cnt_t;

  // {cs, ras, cas, we}, all active low on the pins.
  typedef enum logic [3:0] {
    cmd_nop          = 4'b0111,
    cmd_activate     = 4'b0011,
    cmd_read         = 4'b0101,
    cmd_write        = 4'b0100,
    cmd_precharge    = 4'b0010,
    cmd_auto_refresh = 4'b0001,
    cmd_load_mode    = 4'b0000,
    cmd_burst_stop   = 4'b0110
  } sdram_cmd_t;

  typedef enum logic [3:0] {
    init_wait, init_pre, init_ref, init_lmr,
    idle, refresh, activate,
    wr_cmd, wr_burst, rd_cmd, rd_burst,
    precharge
  } sdram_state_t;

  localparam int cas_latency = 2;

  localparam logic [2:0] burst_len_full_page = 3'b111;
  localparam logic       burst_type_seq      = 1'b0;
  localparam logic [1:0] op_mode_standard    = 2'b00;
  localparam logic       write_burst_mode    = 1'b0; // writes follow the burst length.

  localparam sdram_row_t mode_reg_value = {2'b00, write_burst_mode, op_mode_standard,
                                           3'(cas_latency), burst_type_seq,
                                           burst_len_full_page};

  localparam sdram_row_t precharge_all = 12'h400; // a10 selects all banks.

  localparam int t_power_up       = 14300;
  localparam int t_rp             = 3;
  localparam int t_rfc            = 10;
  localparam int t_rcd            = 3;
  localparam int t_mrd            = 2;
  localparam int refresh_interval = 1100;

  localparam int page_words = 256;

endpackage

// File: verilog/memtest_pkg.sv
// Self-test index and request types, sequencer states, page parity bit and pattern masks.
package memtest_pkg;

  import sdram_pkg::*;

  localparam int index_width = col_width;

  typedef logic [index_width-1:0] word_index_t;

  typedef enum logic [1:0] {
    op_none,
    op_write,
    op_read
  } op_t;

  typedef enum logic [2:0] {
    wr, wr_wait, rd, rd_wait, cmp_done, stop
  } memtest_state_t;

  localparam int parity_bit = col_width; // lowest page number bit of the address.

  localparam sdram_word_t even_page_mask = 16'h0000;
  localparam sdram_word_t odd_page_mask  = 16'hffff;

endpackage

// File: verilog/sdram_ctrl.sv
// SDRAM controller: power-up init, refresh timer, activate and full-page burst write/read.
module sdram_ctrl
  import sdram_pkg::*;
  import memtest_pkg::*;
(
  input  logic             w_c0,
  input  logic             reset,
  input  op_t              req,
  input  sdram_addr_t      addr_in,
  output logic             ack,
  input  sdram_word_t      wr_data,
  output logic             wr_next,
  output sdram_word_t      rd_data,
  output logic             rd_valid,
  output logic             done,
  inout  wire sdram_word_t dq,
  output logic [11:0]      addr,
  output logic [1:0]       bs,
  output logic             cke,
  output logic             cs,
  output logic             ras,
  output logic             cas,
  output logic             we,
  output logic [1:0]       dqm
);

  sdram_state_t         state;
  sdram_cmd_t           cmd_q;
  sdram_row_t           addr_q;
  sdram_bank_t          bs_q;
  sdram_word_t          dq_out;
  logic                 dq_oe;
  wait_cnt_t            wait_cnt;
  burst_cnt_t           burst_cnt;
  refresh_cnt_t         refresh_cnt;
  logic                 ref_pending;
  logic                 init_second;
  logic [cas_latency:0] rd_pipe;
  logic                 rd_fire;
  logic                 wait_zero;
  logic                 burst_move;
  sdram_bank_t          req_bank;
  sdram_row_t           req_row;
  sdram_col_t           req_col;

  assign {req_bank, req_row, req_col} = addr_in;

  assign wait_zero  = (wait_cnt == '0);
  assign burst_move = (burst_cnt < burst_cnt_t'(page_words)); // words still to transfer.

  assign ack     = (state == wr_cmd) || (state == rd_cmd);
  assign wr_next = (state == wr_cmd) || ((state == wr_burst) && burst_move);
  assign rd_fire = (state == rd_cmd) || ((state == rd_burst) && burst_move);
  // only after the last captured word has left the read pipe.
  assign done    = (state == precharge) && wait_zero && (rd_pipe == '0) && !rd_valid;

  assign {cs, ras, cas, we} = cmd_q;
  assign addr = addr_q;
  assign bs   = bs_q;
  assign cke  = 1'b1;
  assign dqm  = 2'b00; // no byte masking.
  assign dq   = dq_oe ? dq_out : 'z;

  always_ff @(posedge w_c0) begin
    if (reset) begin
      refresh_cnt <= '0;
      ref_pending <= 1'b0;
    end else begin
      if ((state == idle) && ref_pending) begin
        ref_pending <= 1'b0;
      end
      if (refresh_cnt == refresh_cnt_t'(refresh_interval - 1)) begin
        refresh_cnt <= '0;
        ref_pending <= 1'b1;
      end else begin
        refresh_cnt <= refresh_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge w_c0) begin
    if (reset) begin
      state       <= init_wait;
      cmd_q       <= cmd_nop;
      addr_q      <= '0;
      bs_q        <= '0;
      dq_oe       <= 1'b0;
      wait_cnt    <= wait_cnt_t'(t_power_up - 1);
      burst_cnt   <= '0;
      init_second <= 1'b0;
    end else begin
      cmd_q <= cmd_nop;
      if (!wait_zero) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
      case (state)
        init_wait: if (wait_zero) begin
          cmd_q    <= cmd_precharge;
          addr_q   <= precharge_all;
          wait_cnt <= wait_cnt_t'(t_rp - 1);
          state    <= init_pre;
        end
        init_pre: if (wait_zero) begin
          cmd_q    <= cmd_auto_refresh;
          wait_cnt <= wait_cnt_t'(t_rfc - 1);
          state    <= init_ref;
        end
        init_ref: if (wait_zero) begin
          if (init_second) begin
            cmd_q    <= cmd_load_mode;
            addr_q   <= mode_reg_value;
            bs_q     <= '0;
            wait_cnt <= wait_cnt_t'(t_mrd - 1);
            state    <= init_lmr;
          end else begin
            cmd_q       <= cmd_auto_refresh; // second init refresh.
            wait_cnt    <= wait_cnt_t'(t_rfc - 1);
            init_second <= 1'b1;
          end
        end
        init_lmr: if (wait_zero) begin
          state <= idle;
        end
        idle: if (ref_pending) begin
          cmd_q    <= cmd_auto_refresh;
          wait_cnt <= wait_cnt_t'(t_rfc - 1);
          state    <= refresh;
        end else if (req != op_none) begin
          cmd_q    <= cmd_activate;
          addr_q   <= req_row;
          bs_q     <= req_bank;
          wait_cnt <= wait_cnt_t'(t_rcd - 1);
          state    <= activate;
        end
        refresh: if (wait_zero) begin
          state <= idle;
        end
        activate: if (wait_zero) begin
          state <= (req == op_read) ? rd_cmd : wr_cmd;
        end
        wr_cmd: begin
          cmd_q     <= cmd_write;
          addr_q    <= sdram_row_t'(req_col); // a10 low, no auto precharge.
          dq_oe     <= 1'b1;
          burst_cnt <= burst_cnt_t'(1);
          state     <= wr_burst;
        end
        rd_cmd: begin
          cmd_q     <= cmd_read;
          addr_q    <= sdram_row_t'(req_col);
          burst_cnt <= burst_cnt_t'(1);
          state     <= rd_burst;
        end
        wr_burst, rd_burst: begin
          if (burst_move) begin
            burst_cnt <= burst_cnt + 1'b1;
          end else if (burst_cnt == burst_cnt_t'(page_words)) begin
            cmd_q     <= cmd_burst_stop; // full page would wrap to column 0.
            dq_oe     <= 1'b0;
            burst_cnt <= burst_cnt + 1'b1;
          end else begin
            cmd_q    <= cmd_precharge;
            addr_q   <= precharge_all;
            wait_cnt <= wait_cnt_t'(t_rp - 1);
            state    <= precharge;
          end
        end
        precharge: if (done) begin
          state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // write word goes out with the command, then one per cycle.
  always_ff @(posedge w_c0) begin
    if (wr_next) begin
      dq_out <= wr_data;
    end
  end

  always_ff @(posedge w_c0) begin
    if (reset) begin
      rd_pipe  <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_pipe  <= {rd_pipe[cas_latency-1:0], rd_fire};
      rd_valid <= rd_pipe[cas_latency];
    end
  end

  always_ff @(posedge w_c0) begin
    if (rd_pipe[cas_latency]) begin
      rd_data <= dq; // word lands cas_latency after its slot plus the pin stage.
    end
  end

endmodule

// File: verilog/sdram_memtest.sv
// Page test sequencer: pattern generation, write, read-back compare and error latch.
module sdram_memtest
  import sdram_pkg::*;
  import memtest_pkg::*;
(
  input  logic        w_c0,
  input  logic        reset,
  output op_t         req,
  output sdram_addr_t addr_out,
  input  logic        ack,
  output sdram_word_t wr_data,
  input  logic        wr_next,
  input  sdram_word_t rd_data,
  input  logic        rd_valid,
  input  logic        done,
  output logic        error,
  output logic        parity
);

  memtest_state_t state;
  sdram_addr_t    page_addr;
  word_index_t    wr_idx;
  word_index_t    rd_idx;
  sdram_word_t    expected;
  logic           mismatch;

  // inverted index high, index low; odd pages flip the whole word.
  function automatic sdram_word_t pattern_word(word_index_t idx, logic odd);
    sdram_word_t base;
    base = {~idx, idx};
    return base ^ (odd ? odd_page_mask : even_page_mask);
  endfunction

  assign addr_out = page_addr;
  assign parity   = page_addr[parity_bit];
  assign wr_data  = pattern_word(wr_idx, parity);
  assign expected = pattern_word(rd_idx, parity);
  assign mismatch = rd_valid && (rd_data != expected);

  always_comb begin
    case (state)
      wr:      req = op_write;
      rd:      req = op_read;
      default: req = op_none;
    endcase
  end

  always_ff @(posedge w_c0) begin
    if (reset) begin
      state     <= wr;
      page_addr <= '0;
      wr_idx    <= '0;
      rd_idx    <= '0;
      error     <= 1'b0;
    end else begin
      if (wr_next) begin
        wr_idx <= wr_idx + 1'b1;
      end
      if (rd_valid) begin
        rd_idx <= rd_idx + 1'b1;
      end
      case (state)
        wr: if (ack) begin
          state <= wr_wait;
        end
        wr_wait: if (done) begin
          state <= rd;
        end
        rd: if (ack) begin
          state <= rd_wait;
        end
        rd_wait: begin
          if (mismatch) begin
            error <= 1'b1;
            state <= stop;
          end else if (done) begin
            state <= cmp_done;
          end
        end
        cmp_done: begin
          page_addr <= page_addr + sdram_addr_t'(page_words); // wraps at the top.
          wr_idx    <= '0;
          rd_idx    <= '0;
          state     <= wr;
        end
        stop: state <= stop; // no further requests.
        default: state <= stop;
      endcase
    end
  end

endmodule

// File: verilog/sdram_top.sv
// Top level: self-test sequencer and SDRAM controller on the chip pins, status LEDs.
module sdram_top
  import sdram_pkg::*;
  import memtest_pkg::*;
(
  input  logic             w_c0,
  input  logic             reset,
  inout  wire sdram_word_t dq,
  output logic [11:0]      addr,
  output logic [1:0]       bs,
  output logic             cke,
  output logic             cs,
  output logic             ras,
  output logic             cas,
  output logic             we,
  output logic [1:0]       dqm,
  output logic [3:0]       led
);

  op_t         req;
  sdram_addr_t req_addr;
  logic        ack;
  sdram_word_t wr_data;
  logic        wr_next;
  sdram_word_t rd_data;
  logic        rd_valid;
  logic        done;
  logic        error;
  logic        parity;

  sdram_memtest u_test (
    .w_c0(w_c0), .reset(reset),
    .req(req), .addr_out(req_addr), .ack(ack),
    .wr_data(wr_data), .wr_next(wr_next),
    .rd_data(rd_data), .rd_valid(rd_valid), .done(done),
    .error(error), .parity(parity)
  );

  sdram_ctrl u_ctrl (
    .w_c0(w_c0), .reset(reset),
    .req(req), .addr_in(req_addr), .ack(ack),
    .wr_data(wr_data), .wr_next(wr_next),
    .rd_data(rd_data), .rd_valid(rd_valid), .done(done),
    .dq(dq), .addr(addr), .bs(bs), .cke(cke),
    .cs(cs), .ras(ras), .cas(cas), .we(we), .dqm(dqm)
  );

  assign led = {2'b11, ~parity, ~error}; // active low, upper two unused.

endmodule

// File: testbench/tb_clock.sv
// Clock and reset generator for the testbench.
module tb_clock (
  output logic w_c0,
  output logic reset
);

  initial begin
    w_c0 = 1'b0;
    forever #10 w_c0 = ~w_c0; // 20 unit period.
  end

  initial begin
    reset = 1'b1;
    repeat (10) @(posedge w_c0);
    @(negedge w_c0);
    reset = 1'b0;
  end

endmodule

// File: testbench/sdram_model.sv
// Behavioral SDRAM chip model: four pages of storage, CAS latency 2 reads, one-shot read fault.
module sdram_model
  import sdram_pkg::*;
(
  input  logic             w_c0,
  inout  wire sdram_word_t dq,
  input  logic [11:0]      addr,
  input  logic [1:0]       bs,
  input  logic             cs,
  input  logic             ras,
  input  logic             cas,
  input  logic             we,
  input  logic             inject_fault
);

  sdram_word_t mem [0:4*page_words-1];
  sdram_row_t  act_row [0:3];
  logic [1:0]  cur_bank   = '0;
  sdram_col_t  col        = '0;
  logic        wr_on      = 1'b0;
  logic        rd_on      = 1'b0;
  logic [8:0]  rd_cnt     = '0;
  logic        fault_now  = 1'b0;
  logic        fault_used = 1'b0;
  logic [16:0] stage1     = '0; // {valid, word}.
  logic [16:0] stage2     = '0;

  assign dq = stage2[16] ? stage2[15:0] : 'z;

  always @(posedge w_c0) begin
    sdram_cmd_t  c;
    sdram_word_t w;
    c = sdram_cmd_t'({cs, ras, cas, we});
    stage2 <= stage1;
    stage1 <= '0;
    case (c)
      cmd_activate: act_row[bs] <= addr;
      cmd_write: begin
        wr_on    <= 1'b1;
        rd_on    <= 1'b0;
        cur_bank <= bs;
        col      <= addr[7:0] + 8'd1;
        mem[{act_row[bs][1:0], addr[7:0]}] <= dq; // first word rides with the command.
      end
      cmd_read: begin
        wr_on    <= 1'b0;
        rd_on    <= 1'b1;
        cur_bank <= bs;
        col      <= addr[7:0] + 8'd1;
        rd_cnt   <= 9'd1;
        w = mem[{act_row[bs][1:0], addr[7:0]}];
        stage1   <= {1'b1, w};
        fault_now <= inject_fault && !fault_used;
        if (inject_fault) begin
          fault_used <= 1'b1;
        end
      end
      cmd_burst_stop, cmd_precharge: begin
        wr_on <= 1'b0;
        rd_on <= 1'b0;
      end
      cmd_nop: begin
        if (wr_on) begin
          mem[{act_row[cur_bank][1:0], col}] <= dq;
          col <= col + 8'd1;
        end
        if (rd_on) begin
          w = mem[{act_row[cur_bank][1:0], col}];
          if (fault_now && rd_cnt == 9'd17) begin
            w[0] = ~w[0]; // single bit fault on word 17.
          end
          stage1 <= {1'b1, w};
          col    <= col + 8'd1;
          rd_cnt <= rd_cnt + 9'd1;
        end
      end
      default: ;
    endcase
  end

endmodule

// File: testbench/tb_top.sv
// Testbench top: reference pattern, pin monitor, compare tasks and test report.
module tb_top;
  import sdram_pkg::*;

  localparam int ref_limit = refresh_interval + page_words + 32;

  // full page, sequential, cas latency 2, burst writes.
  localparam logic [11:0] mode_word = 12'h027;

  logic        w_c0;
  logic        reset;
  logic        inject_fault;
  wire sdram_word_t dq;
  logic [11:0] addr;
  logic [1:0]  bs;
  logic [1:0]  dqm;
  logic        cke;
  logic        cs;
  logic        ras;
  logic        cas;
  logic        we;
  logic [3:0]  led;

  int checks = 0;
  int errors = 0;
  int test_err [0:6];
  int init_seen = 0;
  bit init_done = 1'b0;
  bit in_wr = 1'b0;
  bit in_rd = 1'b0;
  int wr_bursts = 0;
  int rd_bursts = 0;
  int act_count = 0;
  int idx = 0;
  int since_ref = 0;
  bit timed_out = 1'b0;
  int base;

  tb_clock u_clk (.w_c0(w_c0), .reset(reset));

  sdram_top dut0 (
    .w_c0(w_c0), .reset(reset), .dq(dq), .addr(addr), .bs(bs), .cke(cke),
    .cs(cs), .ras(ras), .cas(cas), .we(we), .dqm(dqm), .led(led)
  );

  sdram_model u_mem (
    .w_c0(w_c0), .dq(dq), .addr(addr), .bs(bs), .cs(cs), .ras(ras),
    .cas(cas), .we(we), .inject_fault(inject_fault)
  );

  // inverted index above the index, whole word inverted on odd pages.
  function automatic sdram_word_t ref_word(int page, int index);
    logic [7:0]  i;
    sdram_word_t w;
    i = index[7:0];
    w = {~i, i};
    if (page % 2 == 1) begin
      w = ~w;
    end
    return w;
  endfunction

  function automatic sdram_cmd_t init_cmd(int n);
    case (n)
      0:       return cmd_precharge;
      1, 2:    return cmd_auto_refresh;
      default: return cmd_load_mode;
    endcase
  endfunction

  task automatic note_error(int t);
    errors++;
    test_err[t]++;
  endtask

  task automatic check_word(int t, string what, sdram_word_t got, sdram_word_t exp);
    checks++;
    if (got !== exp) begin
      note_error(t);
      $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cmd(int t, string what, sdram_cmd_t got, sdram_cmd_t exp);
    checks++;
    if (got !== exp) begin
      note_error(t);
      $display("[FAIL] %0t %s: got %s expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_addr(int t, string what, logic [11:0] got, logic [11:0] exp);
    checks++;
    if (got !== exp) begin
      note_error(t);
      $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(int t, string what, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      note_error(t);
      $display("[FAIL] %0t %s: got %b expected %b", $time, what, got, exp);
    end
  endtask

  always @(posedge w_c0) begin
    sdram_cmd_t c;
    c = sdram_cmd_t'({cs, ras, cas, we});
    if (!reset && !init_done) begin
      if (c != cmd_nop) begin
        check_flag(1, "cke during init", cke, 1'b1);
        check_addr(1, "dqm during init", {10'b0, dqm}, 12'h000);
        if (init_seen < 4) begin
          check_cmd(1, "init command", c, init_cmd(init_seen));
        end
        if (c == cmd_load_mode) begin
          check_addr(1, "mode register", addr, mode_word);
          init_done = 1'b1;
        end
        init_seen++;
      end
    end else if (!reset) begin
      since_ref++;
      if (since_ref > ref_limit) begin
        note_error(4);
        $display("no refresh seen for %0d cycles at time %0t", since_ref, $time);
        since_ref = 0;
      end
      case (c)
        cmd_auto_refresh: begin
          if (in_wr || in_rd) begin
            note_error(4);
            $display("refresh issued inside a burst at time %0t", $time);
          end
          since_ref = 0;
        end
        cmd_activate: begin
          check_addr(3, "activate row", addr, 12'(act_count / 2)); // one page per row.
          check_addr(3, "activate bank", {10'b0, bs}, 12'h000);
          check_flag(3, "parity led", led[1], (act_count / 2) % 2 == 0); // active low.
          act_count++;
        end
        cmd_write: begin
          check_flag(2, "cke during write", cke, 1'b1);
          check_addr(2, "dqm during write", {10'b0, dqm}, 12'h000);
          in_wr = 1'b1;
          idx = 0;
        end
        cmd_read: in_rd = 1'b1;
        cmd_burst_stop: begin
          if (in_wr) begin
            checks++;
            if (idx != page_words) begin
              note_error(2);
              $display("[FAIL] %0t write burst carried %0d words, expected %0d",
                       $time, idx, page_words);
            end
            wr_bursts++;
          end
          if (in_rd) begin
            rd_bursts++;
          end
          in_wr = 1'b0;
          in_rd = 1'b0;
        end
        default: ;
      endcase
      if (in_wr) begin
        if (wr_bursts < 2) begin
          check_word(2, "write data", dq, ref_word(wr_bursts, idx));
        end
        idx++;
      end
    end
  end

  function automatic bit reached(int k, int target);
    case (k)
      0:       return init_done;
      1:       return rd_bursts >= target;
      default: return act_count >= target;
    endcase
  endfunction

  task automatic wait_until(int k, int target, int limit, string what);
    int n;
    n = 0;
    while (!reached(k, target) && n < limit) begin
      @(negedge w_c0);
      n++;
    end
    if (!reached(k, target)) begin
      timed_out = 1'b1;
      errors++;
      $display("timed out at %0t waiting for %s", $time, what);
    end
  endtask

  task automatic report(int t, string name);
    $display("test %0d %s: %0d errors", t, name, test_err[t]);
  endtask

  initial begin
    inject_fault = 1'b0;
    for (int i = 0; i <= 6; i++) begin
      test_err[i] = 0;
    end
    wait_until(0, 0, t_power_up + 500, "init sequence");
    if (!timed_out) begin
      if (init_seen != 4) begin
        note_error(1);
        $display("[FAIL] %0t init took %0d commands, expected 4", $time, init_seen);
      end
      report(1, "init");
      wait_until(1, 3, 6000, "third read burst");
    end
    if (!timed_out) begin
      wait_until(2, 7, 2000, "fourth page activate");
    end
    if (!timed_out) begin
      check_flag(5, "error led after clean pages", led[0], 1'b1);
      report(5, "clean run");
      @(negedge w_c0);
      inject_fault = 1'b1;
      wait_until(1, rd_bursts + 1, 4000, "faulty read burst");
    end
    if (!timed_out) begin
      check_flag(6, "error led after fault", led[0], 1'b0);
      base = act_count;
      repeat (3000) @(negedge w_c0);
      checks++;
      if (act_count != base) begin
        note_error(6);
        $display("activate issued after the error was latched");
      end
      report(6, "fault");
      report(2, "write data");
      report(3, "addressing");
      report(4, "refresh");
    end
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
verilog/sdram_pkg.sv
verilog/memtest_pkg.sv
verilog/sdram_ctrl.sv
verilog/sdram_memtest.sv
verilog/sdram_top.sv
testbench/tb_clock.sv
testbench/sdram_model.sv
testbench/tb_top.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks for the pass message
verilator --binary --timing -f all.f --top-module tb_top -o tb_sim \
  && ./obj_dir/tb_sim | grep -q "TESTS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
